// File: mipsSlice.f
src/mipsPkg.sv
src/controlUnit.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsSlice.sv
tb/clockGen.sv
tb/mipsSliceTb.sv

// File: Makefile
# Verilator flow for the mipsSlice testbench
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module mipsSliceTb \
		-f mipsSlice.f --Mdir $(OBJDIR) -o VmipsSliceTb

# The run passes only if the log holds the pass line
run: compile
	./$(OBJDIR)/VmipsSliceTb | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/mipsSliceTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsSliceTb;

	localparam int DataDepth = 256;
	localparam int ClkPeriod = 100;
	localparam int ResetCycles = 10;
	localparam int NumAlu = 120;
	localparam int NumStores = 24;
	localparam int NumLoads = 32;
	localparam int NumChain = 80;
	localparam int NumSpecial = 6;
	localparam int TotalInstr = 32 + NumAlu + NumStores + NumLoads + NumChain + NumSpecial;

	logic clk, rstN, inValid, inReady;
	logic [31:0] instr;
	mipsPkg::retireT retire;

	logic [15:0] lfsr = 16'd80;           // Seed
	int cycle = 0;                        // Rising edges seen so far
	logic [31:0] modelRegs [32];
	logic [7:0] modelMem [DataDepth*4];   // Byte addressed, little endian
	int busyUntil [32];                   // Retire cycle of the last writer
	mipsPkg::retireT expQ [$];
	int expCycleQ [$];                    // Negedge cycle of each expected retire
	int errorCount = 0;
	int testErrors = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int acceptCount = 0;
	int retireCount = 0;
	int stallCount = 0;
	int memBase = 0;                      // 64-byte window for loads and stores
	string testName = "init";

	mipsPkg::functE functList [13] = '{mipsPkg::F_ADD, mipsPkg::F_SUB, mipsPkg::F_AND,
		mipsPkg::F_OR, mipsPkg::F_XOR, mipsPkg::F_NOR, mipsPkg::F_SLT, mipsPkg::F_SLL,
		mipsPkg::F_SRL, mipsPkg::F_SRA, mipsPkg::F_SLLV, mipsPkg::F_SRLV, mipsPkg::F_SRAV};
	mipsPkg::opcodeE immList [6] = '{mipsPkg::ADDI, mipsPkg::ANDI, mipsPkg::ORI,
		mipsPkg::XORI, mipsPkg::SLTI, mipsPkg::LUI};

	clockGen #(
		.Period (ClkPeriod)
	) clkGen (
		.clk (clk)
	);

	mipsSlice #(
		.DataDepth (DataDepth)
	) uut (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.inReady (inReady),
		.instr   (instr),
		.retire  (retire)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	////////////////////////////////////////////////////////////
	// Stimulus generation
	////////////////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr); // One step per bit
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Small register sets give r1..r4 for dense hazards
	function automatic logic [4:0] pickReg(input int regBits);
		logic [31:0] r;
		r = randBits(regBits);
		return (regBits >= 5) ? r[4:0] : r[4:0] + 5'd1;
	endfunction

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {mipsPkg::RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] aluInstr(input int regBits);
		int sel;
		logic [4:0] rs, rt, rd;
		logic [31:0] shamt, imm;
		sel = int'(randBits(5) % 20);
		rs = pickReg(regBits);
		rt = pickReg(regBits);
		rd = pickReg(regBits);
		shamt = randBits(5);
		imm = randBits(16);
		if (sel < 13)
			return rType(functList[sel], rs, rt, rd, shamt[4:0]);
		else if (sel < 19)
			return iType(immList[sel - 13], rs, rt, imm[15:0]);
		else
			return iType(mipsPkg::ENDOP, rs, rt, imm[15:0]); // No-op
	endfunction

	// Base r0, so the immediate is the byte address
	function automatic logic [31:0] memInstr(input logic isStore, input int regBits);
		int size;
		logic [31:0] addr, u;
		logic [4:0] rt;
		logic [5:0] op;
		size = int'(randBits(2) % 3); // Byte, half, word
		u = randBits(1);
		addr = 32'(memBase) + randBits(6);
		rt = pickReg(regBits);
		if (size == 1)
			addr[0] = 1'b0;
		if (size == 2)
			addr[1:0] = 2'b00;
		if (isStore)
			op = (size == 0) ? mipsPkg::SB : ((size == 1) ? mipsPkg::SH : mipsPkg::SW);
		else if (u[0])
			op = (size == 0) ? mipsPkg::LBU : ((size == 1) ? mipsPkg::LHU : mipsPkg::LWU);
		else
			op = (size == 0) ? mipsPkg::LB : ((size == 1) ? mipsPkg::LH : mipsPkg::LW);
		return iType(op, 5'd0, rt, addr[15:0]);
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// {rs read, rt read, writes a nonzero register, destination}
	function automatic logic [7:0] classify(input logic [31:0] w);
		logic [5:0] op;
		logic rsUsed, rtUsed, writes;
		logic [4:0] dest;
		op = w[31:26];
		rsUsed = 1'b0;
		rtUsed = 1'b0;
		writes = 1'b0;
		dest = w[20:16];
		if (op == mipsPkg::RTYPE)
		begin
			rtUsed = 1'b1;
			rsUsed = !(w[5:0] inside {mipsPkg::F_SLL, mipsPkg::F_SRL, mipsPkg::F_SRA});
			writes = 1'b1;
			dest = w[15:11];
		end
		else if (op inside {mipsPkg::SB, mipsPkg::SH, mipsPkg::SW})
		begin
			rsUsed = 1'b1;
			rtUsed = 1'b1;
		end
		else if (op == mipsPkg::LUI)
			writes = 1'b1; // No source
		else if (op != mipsPkg::ENDOP)
		begin
			rsUsed = 1'b1; // Loads and ALU immediates
			writes = 1'b1;
		end
		return {rsUsed, rtUsed, writes && dest != 5'd0, dest};
	endfunction

	// Sources and destination must not wait on an older writeback
	function automatic logic mustWait(input logic [31:0] w, input int cyc);
		logic [7:0] c;
		c = classify(w);
		return (c[7] && busyUntil[w[25:21]] > cyc) || (c[6] && busyUntil[w[20:16]] > cyc)
			|| (c[5] && busyUntil[c[4:0]] > cyc);
	endfunction

	task automatic runModel(input logic [31:0] w, input int cyc);
		mipsPkg::retireT e;
		logic [7:0] c;
		logic [5:0] op;
		logic [31:0] a, b, sImm, zImm, result, addr;
		logic [3:0] lanes;
		int base, n;
		c = classify(w);
		op = w[31:26];
		a = modelRegs[w[25:21]];
		b = modelRegs[w[20:16]];
		sImm = {{16{w[15]}}, w[15:0]};
		zImm = {16'd0, w[15:0]};
		addr = a + sImm;
		base = int'(addr);
		result = '0;
		e = '0;
		e.valid = 1'b1;
		case (op)
			mipsPkg::RTYPE:
				case (w[5:0])
					mipsPkg::F_ADD:  result = a + b;
					mipsPkg::F_SUB:  result = a - b;
					mipsPkg::F_AND:  result = a & b;
					mipsPkg::F_OR:   result = a | b;
					mipsPkg::F_XOR:  result = a ^ b;
					mipsPkg::F_NOR:  result = ~(a | b);
					mipsPkg::F_SLT:  result = {31'd0, $signed(a) < $signed(b)};
					mipsPkg::F_SLL:  result = b << w[10:6];
					mipsPkg::F_SRL:  result = b >> w[10:6];
					mipsPkg::F_SRA:  result = $unsigned($signed(b) >>> w[10:6]);
					mipsPkg::F_SLLV: result = b << a[4:0];
					mipsPkg::F_SRLV: result = b >> a[4:0];
					mipsPkg::F_SRAV: result = $unsigned($signed(b) >>> a[4:0]);
					default:         result = '0;
				endcase
			mipsPkg::ADDI: result = a + sImm;
			mipsPkg::ANDI: result = a & zImm;
			mipsPkg::ORI:  result = a | zImm;
			mipsPkg::XORI: result = a ^ zImm;
			mipsPkg::SLTI: result = {31'd0, $signed(a) < $signed(sImm)};
			mipsPkg::LUI:  result = {w[15:0], 16'd0};
			mipsPkg::LB:   result = {{24{modelMem[base][7]}}, modelMem[base]};
			mipsPkg::LBU:  result = {24'd0, modelMem[base]};
			mipsPkg::LH:   result = {{16{modelMem[base + 1][7]}}, modelMem[base + 1],
				modelMem[base]};
			mipsPkg::LHU:  result = {16'd0, modelMem[base + 1], modelMem[base]};
			mipsPkg::LW, mipsPkg::LWU:
				result = {modelMem[base + 3], modelMem[base + 2], modelMem[base + 1],
					modelMem[base]};
			mipsPkg::SB, mipsPkg::SH, mipsPkg::SW:
			begin
				n = (op == mipsPkg::SB) ? 1 : ((op == mipsPkg::SH) ? 2 : 4);
				lanes = (n == 1) ? 4'b0001 : ((n == 2) ? 4'b0011 : 4'b1111);
				for (int i = 0; i < n; i++)
					modelMem[base + i] = b[8*i +: 8]; // Low byte at lowest address
				e.storeEn = lanes << addr[1:0];
				e.storeAddr = addr;
				e.storeData = b;
			end
			default: result = '0; // END
		endcase
		e.destReg = c[4:0];
		e.writeEn = c[5];
		e.wbData = result;
		if (c[5])
		begin
			modelRegs[c[4:0]] = result;
			busyUntil[c[4:0]] = cyc + 3;
		end
		expQ.push_back(e);
		expCycleQ.push_back(cyc + 3); // Three negedges after the handshake was seen
	endtask

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("** Error %s: %s expected %h actual %h", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareRetire(input mipsPkg::retireT e);
		checkValue("writeEn", 32'(e.writeEn), 32'(retire.writeEn));
		if (e.writeEn)
		begin
			checkValue("destReg", 32'(e.destReg), 32'(retire.destReg));
			checkValue("wbData", e.wbData, retire.wbData);
		end
		checkValue("storeEn", 32'(e.storeEn), 32'(retire.storeEn));
		if (e.storeEn != 4'b0000)
		begin
			checkValue("storeAddr", e.storeAddr, retire.storeAddr);
			checkValue("storeData", e.storeData, retire.storeData);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin : retireMonitor
		mipsPkg::retireT e;
		if (rstN)
		begin
			if (expCycleQ.size() != 0 && expCycleQ[0] == cycle)
			begin
				e = expQ.pop_front();
				void'(expCycleQ.pop_front());
				if (!retire.valid)
				begin
					$display("%s: an accepted instruction did not retire at cycle %0d",
						testName, cycle);
					errorCount++;
				end
				else
				begin
					retireCount++;
					compareRetire(e);
				end
			end
			else if (retire.valid)
			begin
				$display("%s: retire seen with no instruction due at cycle %0d", testName, cycle);
				errorCount++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Driver and tests
	////////////////////////////////////////////////////////////

	// Called 1 ns after a rising edge, returns 1 ns after the acceptance edge
	task automatic issue(input logic [31:0] w);
		instr = w;
		inValid = 1'b1; // Held until accepted
		do
		begin
			@(negedge clk);
			checkValue("inReady", 32'(!mustWait(w, cycle)), 32'(inReady));
			if (!inReady)
				stallCount++;
		end
		while (!inReady);
		runModel(w, cycle);
		acceptCount++;
		@(posedge clk);
		#1;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrors = errorCount;
		acceptCount = 0;
		retireCount = 0;
		stallCount = 0;
	endtask

	task automatic endTest();
		inValid = 1'b0;
		while (expQ.size() != 0)
			@(negedge clk); // Drain the pipe
		@(posedge clk);
		#1;
		checkValue("retired count", 32'(acceptCount), 32'(retireCount));
		if (errorCount == testErrors)
			testsPassed++;
		else
			testsFailed++;
		$display("Test %s %s: %0d instructions, %0d stall cycles, %0d errors", testName,
			(errorCount == testErrors) ? "ok" : "failed", acceptCount, stallCount,
			errorCount - testErrors);
	endtask

	task automatic resetTest();
		beginTest("reset");
		repeat (4)
		begin
			@(negedge clk);
			checkValue("retire.valid", 32'd0, 32'(retire.valid));
			checkValue("inReady", 32'd1, 32'(inReady));
		end
		@(posedge clk);
		#1;
		for (int r = 0; r < 32; r++)
			issue(rType(mipsPkg::F_ADD, 5'd0, 5'(r), 5'(r), 5'd0)); // rK = r0 + rK
		endTest();
	endtask

	task automatic chainTest();
		logic [31:0] pick;
		beginTest("chain");
		repeat (NumChain)
		begin
			pick = randBits(3);
			if (pick == 0)
				issue(memInstr(1'b1, 2));
			else if (pick == 1)
				issue(memInstr(1'b0, 2));
			else
				issue(aluInstr(2)); // Only r1..r4
		end
		if (stallCount == 0)
		begin
			$display("chain: inReady never dropped during dependent chains");
			errorCount++;
		end
		endTest();
	endtask

	task automatic specialTest();
		beginTest("noWrite");
		issue(iType(mipsPkg::ENDOP, 5'd3, 5'd4, 16'h1234));
		issue(iType(mipsPkg::ADDI, 5'd0, 5'd0, 16'h0055));
		issue(rType(mipsPkg::F_OR, 5'd1, 5'd2, 5'd0, 5'd0));
		issue(iType(mipsPkg::LW, 5'd0, 5'd0, 16'h0000));
		issue(iType(mipsPkg::LUI, 5'd0, 5'd0, 16'hbeef));
		issue(iType(mipsPkg::ORI, 5'd0, 5'd7, 16'h8001)); // Real write after the r0 ones
		endTest();
	endtask

	initial
	begin
		rstN = 1'b0;
		inValid = 1'b0;
		instr = 32'd0;
		for (int r = 0; r < 32; r++)
		begin
			modelRegs[r] = 32'd0;
			busyUntil[r] = 0;
		end
		for (int a = 0; a < DataDepth * 4; a++)
			modelMem[a] = 8'd0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;

		resetTest();
		beginTest("alu");
		repeat (NumAlu) issue(aluInstr(5));
		endTest();
		beginTest("memory");
		memBase = int'(randBits(4)) * 64 % (DataDepth * 4);
		repeat (NumStores) issue(memInstr(1'b1, 5));
		repeat (NumLoads) issue(memInstr(1'b0, 5));
		endTest();
		chainTest();
		specialTest();

		$display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Budget of 20 cycles per instruction
	initial
	begin
		#((ResetCycles + TotalInstr * 20) * ClkPeriod);
		$display("Watchdog: run did not finish within %0d cycles",
			ResetCycles + TotalInstr * 20);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter int Period = 100 // ns
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk; // 50 ns high, 50 ns low
	end

endmodule

`default_nettype wire

// File: src/mipsSlice.sv
`timescale 1ns/100ps
`default_nettype none

module mipsSlice #(
	parameter int DataDepth = 256
) (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  logic [31:0] instr,
	output mipsPkg::retireT retire
);

	logic [4:0] raddrA, raddrB;
	logic [31:0] rdataA, rdataB;
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMem;

	////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////

	decodeStage decode (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.inReady (inReady),
		.instr   (instr),
		.raddrA  (raddrA),
		.raddrB  (raddrB),
		.rdataA  (rdataA),
		.rdataB  (rdataB),
		.wbDone  (retire), // Clears scoreboard bits
		.idEx    (idEx)
	);

	executeStage execute (
		.clk   (clk),
		.rstN  (rstN),
		.idEx  (idEx),
		.exMem (exMem)
	);

	memoryStage #(
		.DataDepth (DataDepth)
	) memory (
		.clk    (clk),
		.rstN   (rstN),
		.exMem  (exMem),
		.retire (retire)
	);

	regFile regs (
		.clk    (clk),
		.rstN   (rstN),
		.raddrA (raddrA),
		.raddrB (raddrB),
		.rdataA (rdataA),
		.rdataB (rdataB),
		.we     (retire.writeEn), // Writeback from the retire record
		.waddr  (retire.destReg),
		.wdata  (retire.wbData)
	);

endmodule

`default_nettype wire

// File: src/memoryStage.sv
`timescale 1ns/100ps
`default_nettype none

module memoryStage #(
	parameter int DataDepth = 256 // 32-bit words
) (
	input  logic clk,
	input  logic rstN,
	input  mipsPkg::exMemT exMem,
	output mipsPkg::retireT retire
);

	localparam int AddrW = $clog2(DataDepth);

	logic [7:0] dataMem [4][DataDepth]; // One array per byte lane
	logic [AddrW-1:0] wordIdx;
	logic [1:0] laneOff;
	logic [3:0] laneEn;
	logic [31:0] laneData, rdWord, rdShift, loadVal;
	logic [15:0] halfSel;
	logic isHalf, isWord;

	assign wordIdx = exMem.aluResult[AddrW+1:2];
	assign laneOff = exMem.aluResult[1:0];

	////////////////////////////////////////////////////////////
	// Store path
	////////////////////////////////////////////////////////////

	assign laneEn = exMem.valid ? (exMem.ctrl.byteEn << laneOff) : 4'b0000;
	assign laneData = exMem.storeData << {laneOff, 3'b000};

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int w = 0; w < DataDepth; w++)
				for (int l = 0; l < 4; l++)
					dataMem[l][w] <= 8'd0;
		end
		else
		begin
			for (int l = 0; l < 4; l++)
				if (laneEn[l])
					dataMem[l][wordIdx] <= laneData[8*l +: 8];
		end
	end

	////////////////////////////////////////////////////////////
	// Load path
	////////////////////////////////////////////////////////////

	assign rdWord = {dataMem[3][wordIdx], dataMem[2][wordIdx], dataMem[1][wordIdx],
		dataMem[0][wordIdx]};
	assign rdShift = rdWord >> {laneOff, 3'b000}; // Addressed byte in [7:0]
	assign halfSel = laneOff[1] ? rdWord[31:16] : rdWord[15:0];

	always_comb
	begin
		case (exMem.ctrl.loadSize)
			mipsPkg::BYTE:
				loadVal = exMem.ctrl.loadUnsigned ? {24'd0, rdShift[7:0]}
					: {{24{rdShift[7]}}, rdShift[7:0]};
			mipsPkg::HALF:
				loadVal = exMem.ctrl.loadUnsigned ? {16'd0, halfSel}
					: {{16{halfSel[15]}}, halfSel};
			default:
				loadVal = rdWord;
		endcase
	end

	// Retire record, writeback fields also drive the regFile
	always_ff @(posedge clk)
	begin
		retire.destReg <= exMem.destReg;
		retire.wbData <= exMem.ctrl.memToReg ? loadVal : exMem.aluResult;
		retire.storeAddr <= exMem.aluResult;
		retire.storeData <= exMem.storeData;
		if (!rstN)
		begin
			retire.valid <= 1'b0;
			retire.writeEn <= 1'b0;
			retire.storeEn <= 4'b0000;
		end
		else
		begin
			retire.valid <= exMem.valid;
			retire.writeEn <= exMem.valid && exMem.ctrl.regWrite && exMem.destReg != 5'd0;
			retire.storeEn <= laneEn;
		end
	end

	// Access size from store lanes or load size
	assign isHalf = (exMem.ctrl.byteEn == 4'b0011)
		|| (exMem.ctrl.memToReg && exMem.ctrl.loadSize == mipsPkg::HALF);
	assign isWord = (exMem.ctrl.byteEn == 4'b1111)
		|| (exMem.ctrl.memToReg && exMem.ctrl.loadSize == mipsPkg::WORD);

	aAligned: assert property (@(posedge clk) disable iff (!rstN)
		exMem.valid |-> !(isHalf && laneOff[0]) && !(isWord && laneOff != 2'b00))
		else $error("memoryStage: misaligned access at %h", exMem.aluResult);

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input  logic clk,
	input  logic rstN,
	input  mipsPkg::idExT idEx,
	output mipsPkg::exMemT exMem
);

	logic [31:0] opA, opB, shiftVal, aluResult;
	logic [4:0] shiftAmt;

	////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////

	assign opA = idEx.rsVal;

	always_comb
	begin
		case (idEx.ctrl.srcB)
			mipsPkg::SRC_IMM:   opB = idEx.imm32;
			mipsPkg::SRC_SHAMT: opB = {27'd0, idEx.shamt};
			default:            opB = idEx.rtVal;
		endcase
	end

	// Shifts move rt, LUI moves the immediate
	assign shiftVal = idEx.ctrl.luiShift ? opB : idEx.rtVal;
	assign shiftAmt = idEx.ctrl.luiShift ? 5'd16
		: (idEx.ctrl.srcB == mipsPkg::SRC_SHAMT ? opB[4:0] : idEx.rsVal[4:0]);

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (idEx.ctrl.aluOp)
			mipsPkg::ALU_ADD: aluResult = opA + opB;
			mipsPkg::ALU_SUB: aluResult = opA - opB;
			mipsPkg::ALU_AND: aluResult = opA & opB;
			mipsPkg::ALU_OR:  aluResult = opA | opB;
			mipsPkg::ALU_XOR: aluResult = opA ^ opB;
			mipsPkg::ALU_NOR: aluResult = ~(opA | opB);
			mipsPkg::ALU_SLL: aluResult = shiftVal << shiftAmt;
			mipsPkg::ALU_SRL: aluResult = shiftVal >> shiftAmt;
			mipsPkg::ALU_SRA: aluResult = $unsigned($signed(shiftVal) >>> shiftAmt);
			mipsPkg::ALU_SLT: aluResult = {31'd0, $signed(opA) < $signed(opB)};
			default:          aluResult = 32'd0;
		endcase
	end

	// Execute to memory register
	always_ff @(posedge clk)
	begin
		exMem.ctrl <= idEx.ctrl;
		exMem.aluResult <= aluResult;
		exMem.storeData <= idEx.rtVal;
		exMem.destReg <= idEx.destReg;
		if (!rstN)
			exMem.valid <= 1'b0;
		else
			exMem.valid <= idEx.valid;
	end

endmodule

`default_nettype wire

// File: src/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  logic [31:0] instr,
	output logic [4:0] raddrA,
	output logic [4:0] raddrB,
	input  logic [31:0] rdataA,
	input  logic [31:0] rdataB,
	input  mipsPkg::retireT wbDone,
	output mipsPkg::idExT idEx
);

	mipsPkg::ctrlWordT ctrl;
	logic [4:0] rs, rt, rd, destReg;
	logic [31:0] imm32;
	logic [31:0] busy;          // One bit per register awaiting writeback
	logic [31:0] setMask, clearMask, busyNow;
	logic usesRs, usesRt, writesReg, hazard, accept;

	////////////////////////////////////////////////////////////
	// Field extraction
	////////////////////////////////////////////////////////////

	controlUnit ctrlUnit (
		.op    (mipsPkg::opcodeE'(instr[31:26])),
		.funct (mipsPkg::functE'(instr[5:0])),
		.ctrl  (ctrl)
	);

	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign destReg = ctrl.regDst ? rd : rt;
	assign imm32 = ctrl.zeroExt ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	assign raddrA = rs;
	assign raddrB = rt;

	////////////////////////////////////////////////////////////
	// Scoreboard
	////////////////////////////////////////////////////////////

	assign usesRt = ctrl.regDst || (ctrl.byteEn != 4'b0000); // R-type and stores
	assign usesRs = (ctrl.regWrite || ctrl.byteEn != 4'b0000)
		&& ctrl.srcB != mipsPkg::SRC_SHAMT && !ctrl.luiShift;
	assign writesReg = ctrl.regWrite && destReg != 5'd0;

	assign clearMask = wbDone.writeEn ? (32'd1 << wbDone.destReg) : 32'd0;
	assign setMask = accept && writesReg ? (32'd1 << destReg) : 32'd0;
	assign busyNow = busy & ~clearMask; // Retiring now, bypassed in regFile

	// A busy destination also stalls, so an older writeback never clears a younger entry
	assign hazard = (usesRs && busyNow[rs]) || (usesRt && busyNow[rt])
		|| (writesReg && busyNow[destReg]);
	assign inReady = !hazard;
	assign accept = inValid && inReady;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			busy <= '0;
		else
			busy <= busyNow | setMask; // Set wins over clear
	end

	// Decode to execute register
	always_ff @(posedge clk)
	begin
		idEx.ctrl <= ctrl;
		idEx.rsVal <= rdataA;
		idEx.rtVal <= rdataB;
		idEx.imm32 <= imm32;
		idEx.shamt <= instr[10:6];
		idEx.destReg <= destReg;
		if (!rstN)
			idEx.valid <= 1'b0;
		else
			idEx.valid <= accept; // Bubble on stall
	end

	aValidFromHandshake: assert property (@(posedge clk) disable iff (!rstN)
		idEx.valid |-> $past(inValid && inReady))
		else $error("decodeStage: idEx.valid without handshake");

	aWbWasBusy: assert property (@(posedge clk) disable iff (!rstN)
		wbDone.writeEn |-> busy[wbDone.destReg])
		else $error("decodeStage: writeback to a register not marked busy");

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input  logic clk,
	input  logic rstN,
	input  logic [4:0] raddrA,
	input  logic [4:0] raddrB,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB,
	input  logic we,
	input  logic [4:0] waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [32];

	// Write seen by a read in the same cycle
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'd0; // r0 hard-wired
		else if (we && waddr == addr)
			return wdata;
		else
			return regs[addr];
	endfunction

	// Reads follow writeback and register contents as well as the address
	always_comb
	begin
		rdataA = readPort(raddrA);
		rdataB = readPort(raddrB);
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0; // Architectural state starts at zero
		end
		else if (we && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

endmodule

`default_nettype wire

// File: src/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input  mipsPkg::opcodeE  op,
	input  mipsPkg::functE   funct,
	output mipsPkg::ctrlWordT ctrl
);

	////////////////////////////////////////////////////////////
	// Control word builders
	////////////////////////////////////////////////////////////

	function automatic mipsPkg::ctrlWordT loadCtrl(input mipsPkg::loadSizeE size,
		input logic isUnsigned);
		mipsPkg::ctrlWordT c;
		c = '0;
		c.regWrite = 1'b1;
		c.memToReg = 1'b1;
		c.loadSize = size;
		c.loadUnsigned = isUnsigned;
		c.srcB = mipsPkg::SRC_IMM;  // Base plus offset
		c.aluOp = mipsPkg::ALU_ADD;
		return c;
	endfunction

	function automatic mipsPkg::ctrlWordT storeCtrl(input logic [3:0] lanes);
		mipsPkg::ctrlWordT c;
		c = '0;
		c.byteEn = lanes;
		c.srcB = mipsPkg::SRC_IMM;
		c.aluOp = mipsPkg::ALU_ADD;
		return c;
	endfunction

	function automatic mipsPkg::ctrlWordT immCtrl(input mipsPkg::aluOpE alu, input logic zext);
		mipsPkg::ctrlWordT c;
		c = '0;
		c.regWrite = 1'b1;
		c.srcB = mipsPkg::SRC_IMM;
		c.aluOp = alu;
		c.zeroExt = zext;
		return c;
	endfunction

	function automatic mipsPkg::ctrlWordT rCtrl(input mipsPkg::aluOpE alu, input mipsPkg::srcBE src);
		mipsPkg::ctrlWordT c;
		c = '0;
		c.regWrite = 1'b1;
		c.regDst = 1'b1; // Result to rd
		c.aluOp = alu;
		c.srcB = src;
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		ctrl = '0; // Unknown codes and END write nothing
		case (op)
			mipsPkg::RTYPE:
			begin
				case (funct)
					mipsPkg::F_ADD:  ctrl = rCtrl(mipsPkg::ALU_ADD, mipsPkg::SRC_REG);
					mipsPkg::F_SUB:  ctrl = rCtrl(mipsPkg::ALU_SUB, mipsPkg::SRC_REG);
					mipsPkg::F_AND:  ctrl = rCtrl(mipsPkg::ALU_AND, mipsPkg::SRC_REG);
					mipsPkg::F_OR:   ctrl = rCtrl(mipsPkg::ALU_OR, mipsPkg::SRC_REG);
					mipsPkg::F_XOR:  ctrl = rCtrl(mipsPkg::ALU_XOR, mipsPkg::SRC_REG);
					mipsPkg::F_NOR:  ctrl = rCtrl(mipsPkg::ALU_NOR, mipsPkg::SRC_REG);
					mipsPkg::F_SLT:  ctrl = rCtrl(mipsPkg::ALU_SLT, mipsPkg::SRC_REG);
					mipsPkg::F_SLL:  ctrl = rCtrl(mipsPkg::ALU_SLL, mipsPkg::SRC_SHAMT);
					mipsPkg::F_SRL:  ctrl = rCtrl(mipsPkg::ALU_SRL, mipsPkg::SRC_SHAMT);
					mipsPkg::F_SRA:  ctrl = rCtrl(mipsPkg::ALU_SRA, mipsPkg::SRC_SHAMT);
					mipsPkg::F_SLLV: ctrl = rCtrl(mipsPkg::ALU_SLL, mipsPkg::SRC_REG);
					mipsPkg::F_SRLV: ctrl = rCtrl(mipsPkg::ALU_SRL, mipsPkg::SRC_REG);
					mipsPkg::F_SRAV: ctrl = rCtrl(mipsPkg::ALU_SRA, mipsPkg::SRC_REG);
					default:         ctrl = '0;
				endcase
			end
			mipsPkg::LB:   ctrl = loadCtrl(mipsPkg::BYTE, 1'b0);
			mipsPkg::LH:   ctrl = loadCtrl(mipsPkg::HALF, 1'b0);
			mipsPkg::LW:   ctrl = loadCtrl(mipsPkg::WORD, 1'b0);
			mipsPkg::LBU:  ctrl = loadCtrl(mipsPkg::BYTE, 1'b1);
			mipsPkg::LHU:  ctrl = loadCtrl(mipsPkg::HALF, 1'b1);
			mipsPkg::LWU:  ctrl = loadCtrl(mipsPkg::WORD, 1'b1);
			mipsPkg::SB:   ctrl = storeCtrl(4'b0001);
			mipsPkg::SH:   ctrl = storeCtrl(4'b0011);
			mipsPkg::SW:   ctrl = storeCtrl(4'b1111);
			mipsPkg::ADDI: ctrl = immCtrl(mipsPkg::ALU_ADD, 1'b0);
			mipsPkg::ANDI: ctrl = immCtrl(mipsPkg::ALU_AND, 1'b1);
			mipsPkg::ORI:  ctrl = immCtrl(mipsPkg::ALU_OR, 1'b1);
			mipsPkg::XORI: ctrl = immCtrl(mipsPkg::ALU_XOR, 1'b1);
			mipsPkg::SLTI: ctrl = immCtrl(mipsPkg::ALU_SLT, 1'b0);
			mipsPkg::LUI:
			begin
				ctrl = immCtrl(mipsPkg::ALU_SLL, 1'b0);
				ctrl.luiShift = 1'b1; // Shift by 16
			end
			default:       ctrl = '0;
		endcase
	end

	// Legal lane patterns, and a store never writes a register
	always_comb
	begin
		assert ((ctrl.byteEn inside {4'b0000, 4'b0001, 4'b0011, 4'b1111})
			&& !(ctrl.byteEn != 4'b0000 && (ctrl.regWrite || ctrl.memToReg)))
			else $error("controlUnit: illegal store control word");
	end

endmodule

`default_nettype wire

// File: src/mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		RTYPE = 6'b000000, // Operation picked by funct
		LB    = 6'b100000,
		LH    = 6'b100001,
		LW    = 6'b100011,
		LBU   = 6'b100100,
		LHU   = 6'b100101,
		LWU   = 6'b100111, // Same as LW on a 32-bit datapath
		SB    = 6'b101000,
		SH    = 6'b101001,
		SW    = 6'b101011,
		ADDI  = 6'b001000,
		ANDI  = 6'b001100,
		ORI   = 6'b001101,
		XORI  = 6'b001110,
		SLTI  = 6'b001010,
		LUI   = 6'b001111,
		ENDOP = 6'b111111  // Retires as a no-op
	} opcodeE;

	typedef enum logic [5:0] {
		F_SLL  = 6'b000000, // Shift by shamt
		F_SRL  = 6'b000010,
		F_SRA  = 6'b000011,
		F_SLLV = 6'b000100, // Shift by rs[4:0]
		F_SRLV = 6'b000110,
		F_SRAV = 6'b000111,
		F_ADD  = 6'b100000,
		F_SUB  = 6'b100010,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_XOR  = 6'b100110,
		F_NOR  = 6'b100111,
		F_SLT  = 6'b101010
	} functE;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_NOR = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7,
		ALU_SRA = 4'd8,
		ALU_SLT = 4'd9  // Signed compare
	} aluOpE;

	typedef enum logic [1:0] {
		SRC_REG   = 2'd0, // rt value
		SRC_IMM   = 2'd1, // Extended immediate
		SRC_SHAMT = 2'd2  // instr[10:6]
	} srcBE;

	typedef enum logic [1:0] {
		WORD = 2'd0,
		BYTE = 2'd1,
		HALF = 2'd2
	} loadSizeE;

	////////////////////////////////////////////////////////////
	// Pipeline records
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic regWrite;
		logic memToReg;     // Writeback from memory
		logic [3:0] byteEn; // Store lanes before address shift
		loadSizeE loadSize;
		logic loadUnsigned;
		aluOpE aluOp;
		srcBE srcB;
		logic regDst;       // rd when set, else rt
		logic zeroExt;      // Logic immediates
		logic luiShift;     // Immediate moved to upper half
	} ctrlWordT;

	typedef struct packed {
		logic valid;
		ctrlWordT ctrl;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm32;
		logic [4:0] shamt;
		logic [4:0] destReg;
	} idExT;

	typedef struct packed {
		logic valid;
		ctrlWordT ctrl;
		logic [31:0] aluResult; // Also the memory address
		logic [31:0] storeData;
		logic [4:0] destReg;
	} exMemT;

	typedef struct packed {
		logic valid;
		logic [4:0] destReg;
		logic writeEn;          // Never set for r0
		logic [31:0] wbData;
		logic [3:0] storeEn;    // Lane enables after address shift
		logic [31:0] storeAddr;
		logic [31:0] storeData; // Unshifted rt value
	} retireT;

endpackage

`default_nettype wire
